// ==== decode_cases.txt ====
# instr pc stall hazard op rd fmt(0 none 1 I 2 S 3 B 4 U 5 J) src(first second third)
# src digits: 0 zero, 1 register, 2 pc for first / immediate for second and third
002081B3 00001000 0 0 00 00 0 110
40520333 00001004 0 0 01 00 0 110
0083C4B3 00001008 0 0 08 03 0 110
40B55633 0000100C 0 0 12 06 0 110
FFB08693 00001010 0 0 00 09 1 122
06412713 00001014 0 0 02 0C 1 122
7FF1F793 00001018 0 0 0A 0D 1 122
40325813 0000101C 0 0 12 0E 1 122
123458B7 00001020 0 0 28 0F 4 222
FFFFF917 00001024 0 0 00 10 4 222
FF1FF0EF 00001028 0 0 1E 11 5 222
008289E7 0000102C 0 0 1F 12 1 122
00730463 00001030 0 0 18 01 3 112
FEA4FEE3 00001034 0 0 1D 13 3 112
0220A023 00001038 0 0 27 08 2 121
0001AA03 0000103C 0 1 22 1D 1 122
0001AA03 0000103C 0 1 22 00 1 122
0001AA03 0000103C 0 0 22 00 1 122
014A0AB3 00001040 0 1 00 00 0 110
014A0AB3 00001040 0 0 00 14 0 110
0020EB33 00001044 1 0 09 00 0 110
0020EB33 00001044 1 0 09 00 0 110
0020EB33 00001044 0 0 09 00 0 110
005B7BB3 00001048 1 1 0A 15 0 110
005B7BB3 00001048 0 1 0A 15 0 110
005B7BB3 00001048 0 0 0A 16 0 110
300110F3 0000104C 0 0 2F 00 0 110
00000073 00001050 0 0 2F 17 0 110
00000013 00001054 0 0 29 01 1 122
00401023 00001058 0 0 26 00 2 121
00530023 0000105C 0 1 25 00 2 121
00530023 0000105C 0 1 25 00 2 121
00530023 0000105C 0 0 25 00 2 121
00411C93 00001060 0 0 10 00 1 122
FFE0DD03 00001064 0 1 24 00 1 122
FFE0DD03 00001064 0 0 24 19 1 122

// ==== all.f ====
decode_pkg.sv
instr_classifier.sv
imm_gen.sv
hazard_unit.sv
operand_issue.sv
decode_stage.sv
decode_assert.sv
decode_tb.sv

// ==== Makefile ====
all: run

compile:
	verilator --binary --timing --assert --top-module decode_tb -f all.f -o Vdecode_tb

run: compile
	./obj_dir/Vdecode_tb > run.log 2>&1 || echo "test failed" >> run.log
	cat run.log
	! grep -q "test failed" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean

// ==== decode_tb.sv ====
//////////////////////////////
// Decode stage testbench
// File-driven cases against a model register bank
//////////////////////////////
`timescale 1ns/1ps

module decode_tb
    import decode_pkg::*;
();

    localparam int MAX_CASES = 64;

    logic      clk;
    logic      reset;
    logic      stall;
    word_t     instr;
    word_t     pc;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      hazard;
    issue_t    issue;

    word_t      bank [32];                              // Model register bank
    word_t      c_instr [MAX_CASES];
    word_t      c_pc [MAX_CASES];
    logic       c_stall [MAX_CASES];
    logic       c_hazard [MAX_CASES];
    logic [5:0] c_op [MAX_CASES];
    reg_addr_t  c_rd [MAX_CASES];
    logic [2:0] c_fmt [MAX_CASES];
    logic [11:0] c_src [MAX_CASES];

    int          n_cases;
    int          errors;
    int          checks;
    int          fd;
    int          fields;
    logic        loaded;
    logic        replay;
    string       line;
    logic [31:0] t_instr, t_pc, t_stall, t_hazard, t_op, t_rd, t_fmt, t_src;
    issue_t      exp_issue;

    assign rs1_data = bank[rs1];                        // Combinational bank read
    assign rs2_data = bank[rs2];

    decode_stage decode_stage_i (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall),
        .instr_i    (instr),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rd_o       (rd),
        .hazard_o   (hazard),
        .issue_o    (issue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // RV32I immediate placement by the format code of the cases file
    function automatic word_t expect_imm(word_t w, logic [2:0] f);
        case (f)
            3'd1: return {{20{w[31]}}, w[31:20]};
            3'd2: return {{20{w[31]}}, w[31:25], w[11:7]};
            3'd3: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            3'd4: return {w[31:12], 12'h000};
            3'd5: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic word_t pick_source(logic [3:0] code, word_t reg_val, word_t alt);
        if (code == 4'd1) return reg_val;
        if (code == 4'd2) return alt;
        return 32'h0;
    endfunction

    function automatic issue_t build_expected(int i);
        issue_t e;
        word_t  w;
        word_t  imm;
        w   = c_instr[i];
        imm = expect_imm(w, c_fmt[i]);
        e.first_operand  = pick_source(c_src[i][11:8], bank[w[19:15]], c_pc[i]);
        e.second_operand = pick_source(c_src[i][7:4], bank[w[24:20]], imm);
        e.third_operand  = pick_source(c_src[i][3:0], bank[w[24:20]], imm);
        e.pc             = c_pc[i];
        e.op             = op_e'(c_op[i]);
        e.exception      = (c_op[i] == 6'h2f);      // Invalid encoding
        return e;
    endfunction

    task automatic compare(string name, word_t exp, word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_issue();
        compare("issue_o.first_operand", exp_issue.first_operand, issue.first_operand);
        compare("issue_o.second_operand", exp_issue.second_operand, issue.second_operand);
        compare("issue_o.third_operand", exp_issue.third_operand, issue.third_operand);
        compare("issue_o.pc", exp_issue.pc, issue.pc);
        compare("issue_o.op", 32'(exp_issue.op), 32'(issue.op));
        compare("issue_o.exception", 32'(exp_issue.exception), 32'(issue.exception));
    endtask

    initial begin
        reset  = 1'b1;
        stall  = 1'b0;
        instr  = NOP_WORD;
        pc     = 32'h0;
        errors = 0;
        checks = 0;
        n_cases = 0;
        loaded = 1'b0;
        replay = 1'b0;
        void'($urandom(32'h9a27));
        bank[0] = 32'h0;                                // x0 always zero
        for (int i = 1; i < 32; i++) bank[i] = $urandom;

        fd = $fopen("decode_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the cases file");
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                if ($fgets(line, fd) > 1 && line[0] != 8'h23) begin
                    fields = $sscanf(line, "%h %h %h %h %h %h %h %h", t_instr, t_pc,
                                     t_stall, t_hazard, t_op, t_rd, t_fmt, t_src);
                    if (fields == 8) begin
                        c_instr[n_cases]  = t_instr;
                        c_pc[n_cases]     = t_pc;
                        c_stall[n_cases]  = t_stall[0];
                        c_hazard[n_cases] = t_hazard[0];
                        c_op[n_cases]     = t_op[5:0];
                        c_rd[n_cases]     = t_rd[4:0];
                        c_fmt[n_cases]    = t_fmt[2:0];
                        c_src[n_cases]    = t_src[11:0];
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        exp_issue    = '0;                              // Bubble after reset
        exp_issue.op = NOP;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_cases; i++) begin
            instr = replay ? ~c_instr[i] : c_instr[i];  // Blocked word comes from the replay
            pc    = c_pc[i];
            stall = c_stall[i];
            #6;                                         // Just before the next edge
            compare("hazard_o", 32'(c_hazard[i]), 32'(hazard));
            compare("rd_o", 32'(c_rd[i]), 32'(rd));
            compare("rs1_o", 32'(c_instr[i][19:15]), 32'(rs1));
            compare("rs2_o", 32'(c_instr[i][24:20]), 32'(rs2));
            check_issue();
            if (!c_stall[i]) begin
                replay = c_hazard[i];
                if (c_hazard[i]) begin
                    exp_issue    = '0;
                    exp_issue.op = NOP;
                end else begin
                    exp_issue = build_expected(i);
                end
            end
            @(posedge clk);
            #1;
        end
        instr = NOP_WORD;
        #6;
        check_issue();                                  // Last issued word

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0 && n_cases > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Twice the case time plus reset
    initial begin
        wait (loaded);
        #(2 * n_cases * 8 + 16 * 8);
        $display("timeout: the case sequence did not complete in time");
        $display("test failed");
        $finish;
    end

endmodule

// ==== decode_assert.sv ====
//////////////////////////////
// Decode stage assertions
// Reset, stall and bubble rules
//////////////////////////////
`timescale 1ns/1ps

module decode_assert
    import decode_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   stall_i,
    input logic   hazard_o,
    input issue_t issue_o
);

    assert property (@(posedge clk) reset |=> issue_o.op == NOP)
        else $error("issue op is not NOP after reset");

    assert property (@(posedge clk) !reset && stall_i |=> $stable(issue_o))
        else $error("issue_o changed during stall");

    // Bubble after a hazard
    assert property (@(posedge clk) !reset && hazard_o && !stall_i
                     |=> issue_o.op == NOP && !issue_o.exception)
        else $error("hazard did not produce a clean bubble");

endmodule

bind decode_stage decode_assert decode_assert_i (
    .clk      (clk),
    .reset    (reset),
    .stall_i  (stall_i),
    .hazard_o (hazard_o),
    .issue_o  (issue_o)
);

// ==== decode_stage.sv ====
//////////////////////////////
// RV32I decode stage
// Classify, detect hazards, issue operands
//////////////////////////////
`timescale 1ns/1ps

module decode_stage
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  word_t     instr_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_o,
    output reg_addr_t rs2_o,
    output reg_addr_t rd_o,
    output logic      hazard_o,
    output issue_t    issue_o
);

    word_t instr_sel;
    op_e   op;
    fmt_e  fmt;
    word_t imm;

    // Register bank read addresses
    assign rs1_o = instr_sel[19:15];
    assign rs2_o = instr_sel[24:20];

    hazard_unit hazard_unit_i (
        .clk         (clk),
        .reset       (reset),
        .stall_i     (stall_i),
        .instr_i     (instr_i),
        .op_i        (op),
        .instr_sel_o (instr_sel),
        .rd_o        (rd_o),
        .hazard_o    (hazard_o)
    );

    instr_classifier instr_classifier_i (
        .instr_i (instr_sel),
        .op_o    (op),
        .fmt_o   (fmt)
    );

    imm_gen imm_gen_i (
        .instr_i (instr_sel),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    operand_issue operand_issue_i (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall_i),
        .hazard_i   (hazard_o),
        .instr_i    (instr_sel),
        .op_i       (op),
        .fmt_i      (fmt),
        .imm_i      (imm),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .issue_o    (issue_o)
    );

endmodule

// ==== operand_issue.sv ====
//////////////////////////////
// Operand issue
// Operand select and issue register
//////////////////////////////
`timescale 1ns/1ps

module operand_issue
    import decode_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   stall_i,
    input  logic   hazard_i,
    input  word_t  instr_i,
    input  op_e    op_i,
    input  fmt_e   fmt_i,
    input  word_t  imm_i,
    input  word_t  pc_i,
    input  word_t  rs1_data_i,
    input  word_t  rs2_data_i,
    output issue_t issue_o
);

    localparam issue_t ISSUE_BUBBLE = '{
        first_operand:  '0,
        second_operand: '0,
        third_operand:  '0,
        pc:             '0,
        op:             NOP,
        exception:      1'b0
    };

    word_t  rs1_val;
    word_t  rs2_val;
    issue_t issue_next;

    // x0 reads as zero whatever the bank returns
    assign rs1_val = (instr_i[19:15] == 5'd0) ? '0 : rs1_data_i;
    assign rs2_val = (instr_i[24:20] == 5'd0) ? '0 : rs2_data_i;

    always_comb begin
        issue_next.first_operand  = (fmt_i == U_FMT || fmt_i == J_FMT) ? pc_i : rs1_val;
        issue_next.second_operand = (fmt_i == R_FMT || fmt_i == B_FMT) ? rs2_val : imm_i;
        issue_next.third_operand  = (fmt_i == S_FMT) ? rs2_val : imm_i;  // Store data
        issue_next.pc             = pc_i;
        issue_next.op             = op_i;
        issue_next.exception      = (op_i == INVALID);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_o <= ISSUE_BUBBLE;
        end else if (!stall_i) begin                    // Stall holds the register
            if (hazard_i) begin
                issue_o <= ISSUE_BUBBLE;
            end else begin
                issue_o <= issue_next;
            end
        end
    end

endmodule

// ==== hazard_unit.sv ====
//////////////////////////////
// Hazard control
// Replay register, register lock queue, bubble decision
//////////////////////////////
`timescale 1ns/1ps

module hazard_unit
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      stall_i,
    input  word_t     instr_i,
    input  op_e       op_i,
    output word_t     instr_sel_o,
    output reg_addr_t rd_o,
    output logic      hazard_o
);

    typedef struct packed {
        reg_addr_t rd;
        logic      store;
    } lock_slot_t;

    logic       replay_q;
    word_t      replay_word_q;
    lock_slot_t lock_q [2];
    lock_slot_t lock_next;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       is_store;
    logic       mem_conflict;
    logic       raw_conflict;

    //////////////////////////////
    // Replay of a blocked word
    //////////////////////////////

    assign instr_sel_o = replay_q ? replay_word_q : instr_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            replay_q <= 1'b0;
        end else if (!stall_i) begin
            replay_q <= hazard_o;                       // Decode the same word again
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            replay_word_q <= instr_sel_o;
        end
    end

    //////////////////////////////
    // Hazard decision
    //////////////////////////////

    assign rs1      = instr_sel_o[19:15];
    assign rs2      = instr_sel_o[24:20];
    assign is_store = op_i inside {SB, SH, SW};

    assign mem_conflict = (unit_e'(op_i[5:3]) == MEMORY_UNIT)
                          && (lock_q[0].store || lock_q[1].store);
    assign raw_conflict = (rs1 != '0 && rs1 == lock_q[0].rd) || (rs2 != '0 && rs2 == lock_q[0].rd);
    assign hazard_o     = mem_conflict || raw_conflict;

    //////////////////////////////
    // Register lock queue
    //////////////////////////////

    assign lock_next.rd    = hazard_o ? '0 : instr_sel_o[11:7];  // Bubble locks nothing
    assign lock_next.store = hazard_o ? 1'b0 : is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            lock_q[0] <= '0;
            lock_q[1] <= '0;
        end else if (!stall_i) begin
            lock_q[0] <= lock_next;
            lock_q[1] <= lock_q[0];
        end
    end

    assign rd_o = lock_q[1].rd;                         // Writeback address

endmodule

// ==== imm_gen.sv ====
//////////////////////////////
// Immediate generator
// Sign-extended immediate per format
//////////////////////////////
`timescale 1ns/1ps

module imm_gen
    import decode_pkg::*;
(
    input  word_t instr_i,
    input  fmt_e  fmt_i,
    output word_t imm_o
);

    logic sign;

    assign sign = instr_i[31];                          // Sign bit in every format

    always_comb begin
        case (fmt_i)
            I_FMT: imm_o = {{21{sign}}, instr_i[30:20]};
            S_FMT: imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            B_FMT: begin                                // Branch offset, always even
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            U_FMT: imm_o = {instr_i[31:12], 12'b0};
            J_FMT: begin                                // Jump offset, always even
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;                        // R format has no immediate
        endcase
    end

endmodule

// ==== instr_classifier.sv ====
//////////////////////////////
// Instruction classifier
// Maps an RV32I word to operation and format
//////////////////////////////
`timescale 1ns/1ps

module instr_classifier
    import decode_pkg::*;
(
    input  word_t instr_i,
    output op_e   op_o,
    output fmt_e  fmt_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    always_comb begin
        op_o = INVALID;                                 // Anything not matched below
        if (instr_i == NOP_WORD) begin
            op_o = NOP;
        end else begin
            case (opcode)
                OPC_LUI:   op_o = LUI;
                OPC_AUIPC: op_o = ADD;                  // PC + upper immediate
                OPC_JAL:   op_o = JAL;
                OPC_JALR:  if (funct3 == 3'b000) op_o = JALR;
                OPC_BRANCH: begin
                    case (funct3)
                        3'b000: op_o = BEQ;
                        3'b001: op_o = BNE;
                        3'b100: op_o = BLT;
                        3'b101: op_o = BGE;
                        3'b110: op_o = BLTU;
                        3'b111: op_o = BGEU;
                        default: op_o = INVALID;
                    endcase
                end
                OPC_LOAD: begin
                    case (funct3)
                        3'b000: op_o = LB;
                        3'b001: op_o = LH;
                        3'b010: op_o = LW;
                        3'b100: op_o = LBU;
                        3'b101: op_o = LHU;
                        default: op_o = INVALID;
                    endcase
                end
                OPC_STORE: begin
                    case (funct3)
                        3'b000: op_o = SB;
                        3'b001: op_o = SH;
                        3'b010: op_o = SW;
                        default: op_o = INVALID;
                    endcase
                end
                OPC_OP_IMM: begin
                    case (funct3)
                        3'b000: op_o = ADD;
                        3'b010: op_o = SLT;
                        3'b011: op_o = SLTU;
                        3'b100: op_o = XOR;
                        3'b110: op_o = OR;
                        3'b111: op_o = AND;
                        3'b001: if (funct7 == 7'b0000000) op_o = SLL;
                        default: begin                  // Shift right, funct7 picks the kind
                            if (funct7 == 7'b0000000) op_o = SRL;
                            else if (funct7 == 7'b0100000) op_o = SRA;
                        end
                    endcase
                end
                OPC_OP: begin
                    case ({funct7, funct3})
                        10'b0000000_000: op_o = ADD;
                        10'b0100000_000: op_o = SUB;
                        10'b0000000_001: op_o = SLL;
                        10'b0000000_010: op_o = SLT;
                        10'b0000000_011: op_o = SLTU;
                        10'b0000000_100: op_o = XOR;
                        10'b0000000_101: op_o = SRL;
                        10'b0100000_101: op_o = SRA;
                        10'b0000000_110: op_o = OR;
                        10'b0000000_111: op_o = AND;
                        default: op_o = INVALID;
                    endcase
                end
                default: op_o = INVALID;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            OPC_LOAD, OPC_OP_IMM, OPC_JALR: fmt_o = I_FMT;
            OPC_STORE:                      fmt_o = S_FMT;
            OPC_BRANCH:                     fmt_o = B_FMT;
            OPC_LUI, OPC_AUIPC:             fmt_o = U_FMT;
            OPC_JAL:                        fmt_o = J_FMT;
            default:                        fmt_o = R_FMT;
        endcase
    end

endmodule

// ==== decode_pkg.sv ====
//////////////////////////////
// Decode stage definitions
// Opcodes, operation and format codes, issue bundle
//////////////////////////////
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes, instruction bits 6:0
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam word_t NOP_WORD = 32'h0000_0013;         // addi x0, x0, 0

    typedef enum logic [2:0] {
        ADDER_UNIT  = 3'd0,
        LOGIC_UNIT  = 3'd1,
        SHIFT_UNIT  = 3'd2,
        BRANCH_UNIT = 3'd3,
        MEMORY_UNIT = 3'd4,
        OTHER_UNIT  = 3'd5
    } unit_e;

    // Upper three bits carry the unit_e code
    typedef enum logic [5:0] {
        ADD  = 6'b000_000, SUB  = 6'b000_001, SLT  = 6'b000_010, SLTU = 6'b000_011,
        XOR  = 6'b001_000, OR   = 6'b001_001, AND  = 6'b001_010,
        SLL  = 6'b010_000, SRL  = 6'b010_001, SRA  = 6'b010_010,
        BEQ  = 6'b011_000, BNE  = 6'b011_001, BLT  = 6'b011_010, BGE  = 6'b011_011,
        BLTU = 6'b011_100, BGEU = 6'b011_101, JAL  = 6'b011_110, JALR = 6'b011_111,
        LB   = 6'b100_000, LH   = 6'b100_001, LW   = 6'b100_010, LBU  = 6'b100_011,
        LHU  = 6'b100_100, SB   = 6'b100_101, SH   = 6'b100_110, SW   = 6'b100_111,
        LUI  = 6'b101_000, NOP  = 6'b101_001, INVALID = 6'b101_111
    } op_e;

    typedef enum logic [2:0] {
        R_FMT, I_FMT, S_FMT, B_FMT, U_FMT, J_FMT
    } fmt_e;

    typedef struct packed {
        word_t first_operand;
        word_t second_operand;
        word_t third_operand;
        word_t pc;
        op_e   op;
        logic  exception;
    } issue_t;

endpackage
